// ==== Makefile ====
TOP = tb_tilemap_mixer

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+source
source/tile_video_pkg.sv
source/wb_bus_pkg.sv
source/layer_priority_regs.sv
source/tile_fetch_sequencer.sv
source/tile_layer_mixer.sv
source/tilemap_mixer_top.sv
sim/tb_clock_gen.sv
sim/tb_tilemap_mixer.sv

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK_6M,
	output logic rst
);

	// 40 ns period
	initial begin
		CLK_6M = 1'b0;
		forever begin
			#20 CLK_6M = ~CLK_6M;
		end
	end

	// held for two rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge CLK_6M);
		@(negedge CLK_6M);
		rst = 1'b0;
	end

endmodule

// ==== sim/tb_tilemap_mixer.sv ====
`timescale 1ns/1ps
`include "tile_video_macros.svh"

module tb_tilemap_mixer;

	localparam int MEM_TILES = 8;

	logic                         CLK_6M;
	logic                         rst;
	wb_bus_pkg::wb_req_s          wb_req;
	wb_bus_pkg::wb_rsp_s          wb_rsp;
	tile_video_pkg::layer_sel_e   fetch_layer;
	tile_video_pkg::tile_fetch_s  fetch_data;
	tile_video_pkg::layer_pixel_s chain_in;
	tile_video_pkg::layer_pixel_s pix_out;

	// tile memory contents and chain source
	tile_video_pkg::tile_fetch_s  mem_a [MEM_TILES];
	tile_video_pkg::tile_fetch_s  mem_b [MEM_TILES];
	tile_video_pkg::layer_pixel_s chain_fixed;
	logic                         chain_rand;

	// reference model state
	tile_video_pkg::layer_ctrl_s  m_ctrl;
	logic [1:0]                   g_m;
	tile_video_pkg::tile_fetch_s  hold_m [2];
	tile_video_pkg::color_t       attr_m [2];
	tile_video_pkg::dot_t         lane [2][4];
	tile_video_pkg::layer_pixel_s exp_pix;
	logic                         exp_valid;

	int pix_errors;
	int pix_checks;
	int misc_errors;
	int tests_run;
	int tests_failed;
	int err_mark;

	tb_clock_gen u_clk (
		.CLK_6M (CLK_6M),
		.rst    (rst)
	);

	tilemap_mixer_top dut (
		.CLK_6M      (CLK_6M),
		.rst         (rst),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.fetch_layer (fetch_layer),
		.fetch_data  (fetch_data),
		.chain_in    (chain_in),
		.pix_out     (pix_out)
	);

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic tile_video_pkg::layer_pixel_s mix_ref(
		input tile_video_pkg::layer_ctrl_s  c,
		input tile_video_pkg::dot_t         dot_a,
		input tile_video_pkg::color_t       attr_a,
		input tile_video_pkg::dot_t         dot_b,
		input tile_video_pkg::color_t       attr_b,
		input tile_video_pkg::layer_pixel_s chain
	);
		tile_video_pkg::layer_pixel_s pa;
		tile_video_pkg::layer_pixel_s pb;
		tile_video_pkg::layer_pixel_s win;
		logic ok_a;
		logic ok_b;
		pa = '{prio: c.prio_a, color: attr_a, dot: dot_a};
		pb = '{prio: c.prio_b, color: attr_b, dot: dot_b};
		ok_a = !c.disable_a && (dot_a != `TRANSPARENT_DOT) && (c.prio_a > chain.prio);
		ok_b = !c.disable_b && (dot_b != `TRANSPARENT_DOT) && (c.prio_b > chain.prio);
		if (ok_a && ok_b) begin
			win = (c.prio_b > c.prio_a) ? pb : pa;
		end else if (ok_a) begin
			win = pa;
		end else if (ok_b) begin
			win = pb;
		end else begin
			win = chain;
		end
		return win;
	endfunction

	// flip shows the rightmost pixel first
	function automatic tile_video_pkg::dot_t front_dot(input int l);
		return m_ctrl.flip ? lane[l][0] : lane[l][3];
	endfunction

	// lane index 3 is the leftmost pixel
	task automatic step_layer(input int l, input logic load, input tile_video_pkg::tile_fetch_s t);
		if (load) begin
			attr_m[l] = t.attr;
			for (int p = 0; p < 4; p++) begin
				lane[l][p] = {t.pattern[2][p], t.pattern[1][p], t.pattern[0][p]};
			end
		end else if (m_ctrl.flip) begin
			for (int p = 0; p < 3; p++) begin
				lane[l][p] = lane[l][p+1];
			end
			lane[l][3] = '0;
		end else begin
			for (int p = 3; p > 0; p--) begin
				lane[l][p] = lane[l][p-1];
			end
			lane[l][0] = '0;
		end
	endtask

	initial begin
		exp_valid = 1'b0;
		exp_pix = '0;
		forever begin
			@(posedge CLK_6M);
			if (rst) begin
				g_m = 2'd0;
				for (int l = 0; l < 2; l++) begin
					hold_m[l] = '0;
					attr_m[l] = '0;
					for (int p = 0; p < 4; p++) begin
						lane[l][p] = '0;
					end
				end
				exp_pix = '0;
			end else begin
				exp_pix = mix_ref(m_ctrl, front_dot(0), attr_m[0], front_dot(1), attr_m[1],
					chain_in);
				// loads come half a group after each capture
				step_layer(0, g_m == 2'd3, hold_m[0]);
				step_layer(1, g_m == 2'd1, hold_m[1]);
				if (g_m == 2'd1) begin
					hold_m[0] = fetch_data;
				end
				if (g_m == 2'd3) begin
					hold_m[1] = fetch_data;
				end
				g_m = g_m + 2'd1;
			end
			exp_valid = 1'b1;
		end
	end

	// pix_out is stable at the falling edge
	initial begin
		tile_video_pkg::layer_sel_e exp_layer;
		pix_errors = 0;
		pix_checks = 0;
		forever begin
			@(negedge CLK_6M);
			if (exp_valid) begin
				pix_checks++;
				assert (pix_out === exp_pix) else begin
					$display("[ERROR] %0t ns pix_out expected %h got %h", $time, exp_pix, pix_out);
					pix_errors++;
				end
				// phases 0 and 1 serve layer A
				if (g_m == 2'd0 || g_m == 2'd1) begin
					exp_layer = tile_video_pkg::LAYER_A;
				end else begin
					exp_layer = tile_video_pkg::LAYER_B;
				end
				assert (fetch_layer === exp_layer) else begin
					$display("[ERROR] %0t ns fetch_layer expected %0d got %0d", $time,
						exp_layer, fetch_layer);
					misc_errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// tile memory and chain driver
	//////////////////////////////////////////////////

	initial begin
		int grp;
		tile_video_pkg::layer_sel_e prev;
		grp = 0;
		prev = tile_video_pkg::LAYER_A;
		fetch_data = '0;
		chain_in = '0;
		forever begin
			@(negedge CLK_6M);
			// next tile pair once the B half is over
			if (prev == tile_video_pkg::LAYER_B && fetch_layer == tile_video_pkg::LAYER_A) begin
				grp = (grp + 1) % MEM_TILES;
			end
			prev = fetch_layer;
			fetch_data = (fetch_layer == tile_video_pkg::LAYER_A) ? mem_a[grp] : mem_b[grp];
			if (chain_rand) begin
				chain_in = '{prio: 3'($urandom_range(0, 7)), color: 8'($urandom),
					dot: 3'($urandom_range(0, 7))};
			end else begin
				chain_in = chain_fixed;
			end
		end
	end

	function automatic tile_video_pkg::tile_fetch_s make_tile(input logic with_clear);
		tile_video_pkg::tile_fetch_s t;
		tile_video_pkg::dot_t d;
		t.attr = 8'($urandom);
		for (int p = 0; p < 4; p++) begin
			if (with_clear && $urandom_range(0, 2) == 0) begin
				d = `TRANSPARENT_DOT;
			end else begin
				d = 3'($urandom_range(0, 6));
			end
			t.pattern[2][p] = d[2];
			t.pattern[1][p] = d[1];
			t.pattern[0][p] = d[0];
		end
		return t;
	endfunction

	task automatic fill_tiles(input logic with_clear);
		for (int i = 0; i < MEM_TILES; i++) begin
			mem_a[i] = make_tile(with_clear);
			mem_b[i] = make_tile(with_clear);
		end
	endtask

	//////////////////////////////////////////////////
	// register bus
	//////////////////////////////////////////////////

	task automatic update_ctrl_model(input logic [1:0] adr, input logic [7:0] d);
		case (adr)
			wb_bus_pkg::REG_CTRL: begin
				m_ctrl.flip = d[0];
				m_ctrl.disable_a = d[1];
				m_ctrl.disable_b = d[2];
			end
			wb_bus_pkg::REG_PRIO_A: m_ctrl.prio_a = d[2:0];
			wb_bus_pkg::REG_PRIO_B: m_ctrl.prio_b = d[2:0];
			default: ;
		endcase
	endtask

	function automatic logic [7:0] reg_expect(input logic [1:0] adr);
		case (adr)
			wb_bus_pkg::REG_CTRL: return {5'd0, m_ctrl.disable_b, m_ctrl.disable_a, m_ctrl.flip};
			wb_bus_pkg::REG_PRIO_A: return {5'd0, m_ctrl.prio_a};
			wb_bus_pkg::REG_PRIO_B: return {5'd0, m_ctrl.prio_b};
			default: return 8'd0;
		endcase
	endfunction

	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		logic got;
		got = 1'b0;
		@(negedge CLK_6M);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		for (int i = 0; i < 8 && !got; i++) begin
			@(negedge CLK_6M);
			got = wb_rsp.ack;
		end
		if (!got) begin
			$display("register block gave no ack within 8 cycles");
			misc_errors++;
		end
		rdat = wb_rsp.dat;
		// write lands on the rising edge before this one
		@(negedge CLK_6M);
		assert (!wb_rsp.ack) else begin
			$display("ack stayed high for a second cycle");
			misc_errors++;
		end
		wb_req = '0;
		if (we && got) begin
			update_ctrl_model(adr, wdat);
		end
	endtask

	task automatic write_reg(input logic [1:0] adr, input logic [7:0] d);
		logic [7:0] unused_rd;
		bus_access(1'b1, adr, d, unused_rd);
	endtask

	task automatic read_check(input logic [1:0] adr);
		logic [7:0] rd;
		logic [7:0] exp;
		bus_access(1'b0, adr, 8'd0, rd);
		exp = reg_expect(adr);
		assert (rd === exp) else begin
			$display("[ERROR] %0t ns wb_rsp.dat expected %h got %h", $time, exp, rd);
			misc_errors++;
		end
	endtask

	task automatic set_layers(input logic [7:0] c, input logic [7:0] pa, input logic [7:0] pb);
		write_reg(wb_bus_pkg::REG_CTRL, c);
		write_reg(wb_bus_pkg::REG_PRIO_A, pa);
		write_reg(wb_bus_pkg::REG_PRIO_B, pb);
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	task automatic run_cycles(input int n);
		repeat (n) @(negedge CLK_6M);
	endtask

	task automatic finish_test(input int id, input string name);
		int errs;
		errs = pix_errors + misc_errors - err_mark;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", id, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", id, name, errs);
		end
		err_mark = pix_errors + misc_errors;
	endtask

	task automatic test_registers();
		for (int a = 0; a < 4; a++) begin
			read_check(2'(a));
		end
		write_reg(wb_bus_pkg::REG_CTRL, 8'hff);
		write_reg(wb_bus_pkg::REG_PRIO_A, 8'hfd);
		write_reg(wb_bus_pkg::REG_PRIO_B, 8'h3a);
		write_reg(2'd3, 8'hff);
		for (int a = 0; a < 4; a++) begin
			read_check(2'(a));
		end
		write_reg(wb_bus_pkg::REG_CTRL, 8'h00);
		read_check(wb_bus_pkg::REG_CTRL);
		finish_test(1, "register reset and readback");
	endtask

	task automatic test_opaque();
		fill_tiles(1'b0);
		chain_fixed = '{prio: 3'd0, color: 8'($urandom), dot: 3'($urandom_range(0, 7))};
		set_layers(8'h00, 8'd5, 8'd2);
		run_cycles(64);
		// nothing beats a chain pixel at the top priority
		chain_fixed.prio = 3'd7;
		run_cycles(32);
		finish_test(2, "opaque layers, A in front");
	endtask

	task automatic test_transparency();
		fill_tiles(1'b1);
		chain_fixed = '{prio: 3'd2, color: 8'($urandom), dot: 3'($urandom_range(0, 6))};
		set_layers(8'h00, 8'd5, 8'd3);
		run_cycles(64);
		chain_fixed.prio = 3'd4;
		run_cycles(32);
		finish_test(3, "transparent dots");
	endtask

	task automatic test_swap();
		fill_tiles(1'b0);
		chain_fixed.prio = 3'd0;
		set_layers(8'h00, 8'd3, 8'd6);
		run_cycles(48);
		write_reg(wb_bus_pkg::REG_PRIO_B, 8'd3);
		run_cycles(48);
		finish_test(4, "B in front, then equal priorities");
	endtask

	task automatic test_flip();
		fill_tiles(1'b1);
		set_layers(8'h01, 8'd4, 8'd5);
		run_cycles(64);
		write_reg(wb_bus_pkg::REG_CTRL, 8'h00);
		finish_test(5, "flipped pixel order");
	endtask

	task automatic test_disable_and_random();
		fill_tiles(1'b1);
		set_layers(8'h02, 8'd6, 8'd5);
		run_cycles(32);
		write_reg(wb_bus_pkg::REG_CTRL, 8'h04);
		run_cycles(32);
		write_reg(wb_bus_pkg::REG_CTRL, 8'h06);
		run_cycles(32);
		// mixed traffic with settings changing under it
		chain_rand = 1'b1;
		for (int i = 0; i < 12; i++) begin
			fill_tiles(1'b1);
			set_layers(8'($urandom), 8'($urandom), 8'($urandom));
			run_cycles($urandom_range(20, 40));
		end
		chain_rand = 1'b0;
		finish_test(6, "layer disables and random traffic");
	endtask

	task automatic wait_reset_release();
		for (int i = 0; i < 10 && rst !== 1'b0; i++) begin
			@(negedge CLK_6M);
		end
		if (rst !== 1'b0) begin
			$display("reset was not released within 10 cycles");
			misc_errors++;
		end
	endtask

	initial begin
		void'($urandom(32'h15b8fbfe));
		wb_req = '0;
		chain_fixed = '0;
		chain_rand = 1'b0;
		m_ctrl = '{flip: 1'b0, disable_a: 1'b0, disable_b: 1'b0,
			prio_a: `PRIO_A_RESET, prio_b: `PRIO_B_RESET};
		misc_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		err_mark = 0;
		fill_tiles(1'b0);
		wait_reset_release();
		test_registers();
		test_opaque();
		test_transparency();
		test_swap();
		test_flip();
		test_disable_and_random();
		$display("tests %0d, failed %0d, pixel checks %0d, pixel errors %0d, other errors %0d",
			tests_run, tests_failed, pix_checks, pix_errors, misc_errors);
		if (tests_failed == 0 && pix_errors + misc_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== source/layer_priority_regs.sv ====
`timescale 1ns/1ps
`include "tile_video_macros.svh"

module layer_priority_regs (
	input  logic                        CLK_6M,
	input  logic                        rst,
	input  wb_bus_pkg::wb_req_s         wb_req,
	output wb_bus_pkg::wb_rsp_s         wb_rsp,
	output tile_video_pkg::layer_ctrl_s ctrl
);

	logic                       access;
	logic                       ack_q;
	wb_bus_pkg::reg_idx_e       idx;
	logic [`REG_DATA_WIDTH-1:0] rd_data;

	logic                  flip_q;
	logic                  dis_a_q;
	logic                  dis_b_q;
	tile_video_pkg::prio_t prio_a_q;
	tile_video_pkg::prio_t prio_b_q;

	assign access = wb_req.cyc && wb_req.stb;
	assign idx = wb_bus_pkg::reg_idx_e'(wb_req.adr);

	//////////////////////////////////////////////////
	// bus handshake
	//////////////////////////////////////////////////

	// one wait state, ack drops after a single cycle
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access && !ack_q;
		end
	end

	// write lands on the ack edge
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			flip_q   <= 1'b0;
			dis_a_q  <= 1'b0;
			dis_b_q  <= 1'b0;
			prio_a_q <= `PRIO_A_RESET;
			prio_b_q <= `PRIO_B_RESET;
		end else if (ack_q && wb_req.we) begin
			case (idx)
				wb_bus_pkg::REG_CTRL: begin
					flip_q  <= wb_req.dat[0];
					dis_a_q <= wb_req.dat[1];
					dis_b_q <= wb_req.dat[2];
				end
				wb_bus_pkg::REG_PRIO_A: prio_a_q <= wb_req.dat[2:0];
				wb_bus_pkg::REG_PRIO_B: prio_b_q <= wb_req.dat[2:0];
				default: ;
			endcase
		end
	end

	// readback, upper bits and address 3 read zero
	always_comb begin
		rd_data = '0;
		case (idx)
			wb_bus_pkg::REG_CTRL:   rd_data[2:0] = {dis_b_q, dis_a_q, flip_q};
			wb_bus_pkg::REG_PRIO_A: rd_data[2:0] = prio_a_q;
			wb_bus_pkg::REG_PRIO_B: rd_data[2:0] = prio_b_q;
			default:                rd_data = '0;
		endcase
	end

	assign wb_rsp = '{ack: ack_q, dat: rd_data};

	assign ctrl = '{flip: flip_q, disable_a: dis_a_q, disable_b: dis_b_q,
		prio_a: prio_a_q, prio_b: prio_b_q};

	// master must keep the request up through ack
	assert property (@(posedge CLK_6M) disable iff (rst) ack_q |-> access)
		else $error("ack without cyc and stb");

	assert property (@(posedge CLK_6M) disable iff (rst) ack_q |=> !ack_q)
		else $error("ack high in two consecutive cycles");

endmodule

// ==== source/tile_fetch_sequencer.sv ====
`timescale 1ns/1ps

module tile_fetch_sequencer (
	input  logic                        CLK_6M,
	input  logic                        rst,
	output tile_video_pkg::layer_sel_e  fetch_layer,
	input  tile_video_pkg::tile_fetch_s fetch_data,
	output tile_video_pkg::tile_fetch_s tile_a,
	output tile_video_pkg::tile_fetch_s tile_b,
	output logic                        load_a,
	output logic                        load_b
);

	// group phase, one pixel per step
	logic [1:0] g;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			g <= 2'd0;
		end else begin
			g <= g + 2'd1;
		end
	end

	// first half of the group serves A, second half B
	assign fetch_layer = g[1] ? tile_video_pkg::LAYER_B : tile_video_pkg::LAYER_A;

	//////////////////////////////////////////////////
	// holding registers
	//////////////////////////////////////////////////

	// memory data is taken at the end of each half
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			tile_a <= '0;
			tile_b <= '0;
		end else begin
			if (g == 2'd1) begin
				tile_a <= fetch_data;
			end
			if (g == 2'd3) begin
				tile_b <= fetch_data;
			end
		end
	end

	// each load trails its capture by half a group
	assign load_a = (g == 2'd3);
	assign load_b = (g == 2'd1);

	assert property (@(posedge CLK_6M) disable iff (rst) !(load_a && load_b))
		else $error("load_a and load_b high together");

endmodule

// ==== source/tile_layer_mixer.sv ====
`timescale 1ns/1ps
`include "tile_video_macros.svh"

module tile_layer_mixer (
	input  logic                         CLK_6M,
	input  logic                         rst,
	input  tile_video_pkg::tile_fetch_s  tile_a,
	input  tile_video_pkg::tile_fetch_s  tile_b,
	input  logic                         load_a,
	input  logic                         load_b,
	input  tile_video_pkg::layer_ctrl_s  ctrl,
	input  tile_video_pkg::layer_pixel_s chain_in,
	output tile_video_pkg::layer_pixel_s pix_out
);

	localparam int MSB = `TILE_GROUP_PIXELS - 1;

	// index 0 is layer A, 1 is layer B
	logic [1:0]                        load;
	tile_video_pkg::tile_fetch_s       src [2];
	tile_video_pkg::color_t            attr_q [2];
	tile_video_pkg::plane_t [2:0]      plane_q [2];
	tile_video_pkg::dot_t              dot [2];
	tile_video_pkg::prio_t             prio [2];
	logic [1:0]                        dis;
	logic [1:0]                        elig;
	tile_video_pkg::layer_pixel_s      mix_next;

	assign load = {load_b, load_a};
	assign src[0] = tile_a;
	assign src[1] = tile_b;
	assign prio[0] = ctrl.prio_a;
	assign prio[1] = ctrl.prio_b;
	assign dis = {ctrl.disable_b, ctrl.disable_a};

	//////////////////////////////////////////////////
	// plane shifters
	//////////////////////////////////////////////////

	// normal order pushes toward bit 3, flipped toward bit 0
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			for (int l = 0; l < 2; l++) begin
				attr_q[l]  <= '0;
				plane_q[l] <= '0;
			end
		end else begin
			for (int l = 0; l < 2; l++) begin
				if (load[l]) begin
					attr_q[l]  <= src[l].attr;
					plane_q[l] <= src[l].pattern;
				end else begin
					for (int p = 0; p < 3; p++) begin
						if (ctrl.flip) begin
							plane_q[l][p] <= plane_q[l][p] >> 1;
						end else begin
							plane_q[l][p] <= plane_q[l][p] << 1;
						end
					end
				end
			end
		end
	end

	// current dot, one bit from each plane
	always_comb begin
		for (int l = 0; l < 2; l++) begin
			for (int p = 0; p < 3; p++) begin
				dot[l][p] = ctrl.flip ? plane_q[l][p][0] : plane_q[l][p][MSB];
			end
		end
	end

	//////////////////////////////////////////////////
	// priority mix
	//////////////////////////////////////////////////

	// a layer must beat the chain pixel outright
	always_comb begin
		for (int l = 0; l < 2; l++) begin
			elig[l] = !dis[l] && (dot[l] != `TRANSPARENT_DOT) && (prio[l] > chain_in.prio);
		end
	end

	always_comb begin
		mix_next = chain_in;
		case (elig)
			2'b01: mix_next = '{prio: prio[0], color: attr_q[0], dot: dot[0]};
			2'b10: mix_next = '{prio: prio[1], color: attr_q[1], dot: dot[1]};
			2'b11: begin
				// ties go to A
				if (prio[1] > prio[0]) begin
					mix_next = '{prio: prio[1], color: attr_q[1], dot: dot[1]};
				end else begin
					mix_next = '{prio: prio[0], color: attr_q[0], dot: dot[0]};
				end
			end
			default: mix_next = chain_in;
		endcase
	end

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			pix_out <= '0;
		end else begin
			pix_out <= mix_next;
		end
	end

	// with both layers off the chain dot comes through a cycle later
	assert property (@(posedge CLK_6M) disable iff (rst)
		(ctrl.disable_a && ctrl.disable_b) |=> (pix_out.dot == $past(chain_in.dot)))
		else $error("chain dot lost with both layers disabled");

endmodule

// ==== source/tile_video_macros.svh ====
`ifndef TILE_VIDEO_MACROS_SVH
`define TILE_VIDEO_MACROS_SVH

//////////////////////////////////////////////////
// video format
//////////////////////////////////////////////////

// pixels carried by one pattern plane
`define TILE_GROUP_PIXELS 4
`define TRANSPARENT_DOT 3'd7

//////////////////////////////////////////////////
// register bus
//////////////////////////////////////////////////

`define REG_DATA_WIDTH 8
`define WB_ADR_WIDTH 2

// layer priorities out of reset
`define PRIO_A_RESET 3'd0
`define PRIO_B_RESET 3'd0

`endif

// ==== source/tile_video_pkg.sv ====
`include "tile_video_macros.svh"

package tile_video_pkg;

	// colour index inside a tile, 7 shows what lies behind
	typedef logic [2:0] dot_t;
	// tile attribute, also used as palette bank
	typedef logic [7:0] color_t;
	// higher value is in front
	typedef logic [2:0] prio_t;
	// one bit per pixel, bit 3 is leftmost
	typedef logic [`TILE_GROUP_PIXELS-1:0] plane_t;

	// chain input and mixer output
	typedef struct packed {
		prio_t  prio;
		color_t color;
		dot_t   dot;
	} layer_pixel_s;

	// one fetch from tile memory, plane 2 on top
	typedef struct packed {
		color_t       attr;
		plane_t [2:0] pattern;
	} tile_fetch_s;

	typedef enum logic {
		LAYER_A = 1'b0,
		LAYER_B = 1'b1
	} layer_sel_e;

	typedef struct packed {
		logic  flip;
		logic  disable_a;
		logic  disable_b;
		prio_t prio_a;
		prio_t prio_b;
	} layer_ctrl_s;

endpackage

// ==== source/tilemap_mixer_top.sv ====
`timescale 1ns/1ps

module tilemap_mixer_top (
	input  logic                         CLK_6M,
	input  logic                         rst,
	input  wb_bus_pkg::wb_req_s          wb_req,
	output wb_bus_pkg::wb_rsp_s          wb_rsp,
	output tile_video_pkg::layer_sel_e   fetch_layer,
	input  tile_video_pkg::tile_fetch_s  fetch_data,
	input  tile_video_pkg::layer_pixel_s chain_in,
	output tile_video_pkg::layer_pixel_s pix_out
);

	tile_video_pkg::layer_ctrl_s ctrl;
	tile_video_pkg::tile_fetch_s tile_a;
	tile_video_pkg::tile_fetch_s tile_b;
	logic                        load_a;
	logic                        load_b;

	// cpu side settings
	layer_priority_regs u_regs (
		.CLK_6M (CLK_6M),
		.rst    (rst),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.ctrl   (ctrl)
	);

	// tile memory side
	tile_fetch_sequencer u_seq (
		.CLK_6M      (CLK_6M),
		.rst         (rst),
		.fetch_layer (fetch_layer),
		.fetch_data  (fetch_data),
		.tile_a      (tile_a),
		.tile_b      (tile_b),
		.load_a      (load_a),
		.load_b      (load_b)
	);

	tile_layer_mixer u_mix (
		.CLK_6M   (CLK_6M),
		.rst      (rst),
		.tile_a   (tile_a),
		.tile_b   (tile_b),
		.load_a   (load_a),
		.load_b   (load_b),
		.ctrl     (ctrl),
		.chain_in (chain_in),
		.pix_out  (pix_out)
	);

endmodule

// ==== source/wb_bus_pkg.sv ====
`include "tile_video_macros.svh"

package wb_bus_pkg;

	// master side, held until ack
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`WB_ADR_WIDTH-1:0] adr;
		logic [`REG_DATA_WIDTH-1:0] dat;
	} wb_req_s;

	// slave side
	typedef struct packed {
		logic                       ack;
		logic [`REG_DATA_WIDTH-1:0] dat;
	} wb_rsp_s;

	// register map, address 3 is empty
	typedef enum logic [`WB_ADR_WIDTH-1:0] {
		REG_CTRL   = 2'd0,
		REG_PRIO_A = 2'd1,
		REG_PRIO_B = 2'd2
	} reg_idx_e;

endpackage
